// File: cps_pkg.sv
package cps_pkg;

    // Byte address in the download stream
    typedef logic [24:0] ioctl_addr_t;

    // One byte of the download stream
    typedef logic [7:0] byte_t;

    // Word address inside one SDRAM bank
    typedef logic [21:0] rom_addr_t;

    // One SDRAM word
    typedef logic [15:0] rom_data_t;

    // Bytes at the start of the stream that hold the graphics start
    localparam int HEADER_LEN = 2;

endpackage

// File: cps_rom_map.sv
`timescale 1ns/10ps

module cps_rom_map #(
    parameter int MAP_SHIFT = 10
) (
    input                       clk,
    input                       rst,
    input                       downloading,
    input                       ioctl_wr,
    input  cps_pkg::ioctl_addr_t ioctl_addr,
    input  cps_pkg::byte_t      ioctl_dout,
    output logic                hdr_byte,
    output logic [1:0]          prog_ba,
    output cps_pkg::rom_addr_t  prog_addr,
    output logic                odd_byte
);

// Graphics start, in units of 2**MAP_SHIFT bytes
logic [15:0]          gfx_start;
cps_pkg::ioctl_addr_t offset;
cps_pkg::ioctl_addr_t gfx_base;
cps_pkg::ioctl_addr_t bank_off;
logic                 is_gfx;

always_ff @(posedge clk) begin
    if (rst) begin
        gfx_start <= 16'd0;
    end else if (downloading && ioctl_wr) begin
        if (ioctl_addr == 25'd0) begin
            gfx_start[7:0] <= ioctl_dout;
        end
        if (ioctl_addr == 25'd1) begin
            gfx_start[15:8] <= ioctl_dout;
        end
    end
end

assign hdr_byte = ioctl_addr < cps_pkg::ioctl_addr_t'(cps_pkg::HEADER_LEN);

// Payload offset, meaningless while the header is going through
assign offset   = ioctl_addr - cps_pkg::ioctl_addr_t'(cps_pkg::HEADER_LEN);
assign gfx_base = cps_pkg::ioctl_addr_t'(gfx_start) << MAP_SHIFT;
assign is_gfx   = offset >= gfx_base;
assign bank_off = is_gfx ? offset - gfx_base : offset;

assign prog_ba   = {1'b0, is_gfx};
assign prog_addr = bank_off[22:1];
assign odd_byte  = bank_off[0];

endmodule

// File: cps_dwnld.sv
`timescale 1ns/10ps

module cps_dwnld (
    input                       clk,
    input                       rst,
    input                       downloading,
    input                       ioctl_wr,
    input  cps_pkg::byte_t      ioctl_dout,
    input                       hdr_byte,
    input                       odd_byte,
    input        [1:0]          map_ba,
    input  cps_pkg::rom_addr_t  map_addr,
    output cps_pkg::rom_addr_t  prog_addr,
    output cps_pkg::rom_data_t  prog_data,
    output logic [1:0]          prog_mask,
    output logic [1:0]          prog_ba,
    output logic                prog_we,
    input                       prog_rdy,
    output logic                dwnld_busy
);

typedef enum logic [1:0] {
    st_idle,
    st_write,
    st_release
} state_t;

state_t state;
logic   payload_wr;

// Header bytes stay in the map and never reach the SDRAM
assign payload_wr = downloading && ioctl_wr && !hdr_byte;

always_ff @(posedge clk) begin
    if (rst) begin
        state   <= st_idle;
        prog_we <= 1'b0;
    end else begin
        case (state)
            st_idle: begin
                if (payload_wr) begin
                    prog_we <= 1'b1;
                    state   <= st_write;
                end
            end
            st_write: begin
                if (prog_rdy) begin
                    prog_we <= 1'b0;
                    state   <= st_release;
                end
            end
            st_release: begin
                // Wait for the SDRAM to close its side
                if (!prog_rdy) begin
                    state <= st_idle;
                end
            end
            default: begin
                prog_we <= 1'b0;
                state   <= st_idle;
            end
        endcase
    end
end

// Address, data and lane are held for the whole handshake
always_ff @(posedge clk) begin
    if (state == st_idle && payload_wr) begin
        prog_addr <= map_addr;
        prog_ba   <= map_ba;
        prog_data <= {ioctl_dout, ioctl_dout};
        // Mask is active low, odd bytes land in the upper lane
        prog_mask <= odd_byte ? 2'b01 : 2'b10;
    end
end

assign dwnld_busy = downloading || (state != st_idle);

// The stream source must wait for the previous write to finish
a_byte_spacing: assert property (
    @(posedge clk) disable iff (rst) ioctl_wr |-> state == st_idle
) else $error("ioctl_wr arrived during an open prog write");

endmodule

// File: cps_rom_slot.sv
`timescale 1ns/10ps

module cps_rom_slot (
    input                       clk,
    input                       rst,
    input                       flush,
    input                       cs,
    input  cps_pkg::rom_addr_t  addr,
    output cps_pkg::rom_data_t  data,
    output logic                ok,
    output logic                slot_req,
    input                       slot_ack,
    output cps_pkg::rom_addr_t  slot_addr,
    input  cps_pkg::rom_data_t  slot_data
);

typedef enum logic [1:0] {
    st_idle,
    st_req,
    st_rel
} state_t;

state_t             state;
cps_pkg::rom_addr_t cache_addr;
cps_pkg::rom_data_t cache_data;
logic               cache_valid;
logic               hit;

assign hit  = cache_valid && (cache_addr == addr);
assign data = cache_data;

always_ff @(posedge clk) begin
    if (rst) begin
        state       <= st_idle;
        slot_req    <= 1'b0;
        cache_valid <= 1'b0;
        ok          <= 1'b0;
    end else begin
        ok <= cs && hit && !flush;
        case (state)
            st_idle: begin
                if (cs && !hit && !flush) begin
                    slot_req <= 1'b1;
                    state    <= st_req;
                end
            end
            st_req: begin
                if (slot_ack) begin
                    slot_req    <= 1'b0;
                    cache_valid <= 1'b1;
                    state       <= st_rel;
                end
            end
            st_rel: begin
                if (!slot_ack) begin
                    state <= st_idle;
                end
            end
            default: begin
                slot_req <= 1'b0;
                state    <= st_idle;
            end
        endcase
        // A flush wins over a fill in the same cycle
        if (flush) begin
            cache_valid <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    if (state == st_idle && cs && !hit && !flush) begin
        slot_addr <= addr;
    end
    if (state == st_req && slot_ack) begin
        cache_addr <= slot_addr;
        cache_data <= slot_data;
    end
end

// An ack only ever answers an open request
a_ack_with_req: assert property (
    @(posedge clk) disable iff (rst) state == st_idle |-> !slot_ack
) else $error("slot_ack arrived without an open slot_req");

endmodule

// File: cps_bank_arb.sv
`timescale 1ns/10ps

module cps_bank_arb (
    input                       clk,
    input                       rst,
    input                       downloading,
    input                       req0,
    input                       req1,
    output logic                ack0,
    output logic                ack1,
    input  cps_pkg::rom_addr_t  addr0,
    input  cps_pkg::rom_addr_t  addr1,
    output cps_pkg::rom_data_t  slot_data,
    output logic [1:0]          ba_rd,
    output cps_pkg::rom_addr_t  ba0_addr,
    output cps_pkg::rom_addr_t  ba1_addr,
    input        [1:0]          ba_rdy,
    input  cps_pkg::rom_data_t  data_read
);

typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_ack
} state_t;

state_t state;
logic   sel;
logic   pick;
logic   start;

// Alternate when both wait, otherwise take whoever asks
assign pick  = (req0 && req1) ? !sel : req1;
// Previous bank must have released ba_rdy before a new read
assign start = !downloading && (req0 || req1) && (ba_rdy == 2'b00);

always_ff @(posedge clk) begin
    if (rst) begin
        state <= st_idle;
        ba_rd <= 2'b00;
        ack0  <= 1'b0;
        ack1  <= 1'b0;
        sel   <= 1'b0;
    end else begin
        case (state)
            st_idle: begin
                if (start) begin
                    sel   <= pick;
                    ba_rd <= pick ? 2'b10 : 2'b01;
                    state <= st_read;
                end
            end
            st_read: begin
                if (ba_rdy[sel]) begin
                    ba_rd <= 2'b00;
                    ack0  <= !sel;
                    ack1  <= sel;
                    state <= st_ack;
                end
            end
            st_ack: begin
                if (sel ? !req1 : !req0) begin
                    ack0  <= 1'b0;
                    ack1  <= 1'b0;
                    state <= st_idle;
                end
            end
            default: begin
                ba_rd <= 2'b00;
                state <= st_idle;
            end
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state == st_idle && start) begin
        if (pick) begin
            ba1_addr <= addr1;
        end else begin
            ba0_addr <= addr0;
        end
    end
    if (state == st_read && ba_rdy[sel]) begin
        slot_data <= data_read;
    end
end

// data_read is shared, so only one bank may answer at a time
a_one_bank: assert property (
    @(posedge clk) disable iff (rst) !(ba_rdy[0] && ba_rdy[1])
) else $error("both SDRAM banks answered at once");

endmodule

// File: cps_game.sv
`timescale 1ns/10ps

module cps_game #(
    parameter int MAP_SHIFT = 10
) (
    input                       clk,
    input                       rst,
    input                       downloading,
    output                      dwnld_busy,
    // ROM download
    input  cps_pkg::ioctl_addr_t ioctl_addr,
    input  cps_pkg::byte_t      ioctl_dout,
    input                       ioctl_wr,
    output cps_pkg::rom_addr_t  prog_addr,
    output cps_pkg::rom_data_t  prog_data,
    output       [1:0]          prog_mask,
    output       [1:0]          prog_ba,
    output                      prog_we,
    input                       prog_rdy,
    // Main CPU ROM
    input                       main_rom_cs,
    input  cps_pkg::rom_addr_t  main_rom_addr,
    output cps_pkg::rom_data_t  main_rom_data,
    output                      main_rom_ok,
    // Graphics ROM
    input                       gfx_rom_cs,
    input  cps_pkg::rom_addr_t  gfx_rom_addr,
    output cps_pkg::rom_data_t  gfx_rom_data,
    output                      gfx_rom_ok,
    // SDRAM banks
    output       [1:0]          ba_rd,
    output cps_pkg::rom_addr_t  ba0_addr,
    output cps_pkg::rom_addr_t  ba1_addr,
    input        [1:0]          ba_rdy,
    input  cps_pkg::rom_data_t  data_read
);

wire                     hdr_byte, odd_byte;
wire [1:0]               map_ba;
cps_pkg::rom_addr_t      map_addr;
wire                     main_req, main_ack, gfx_req, gfx_ack;
cps_pkg::rom_addr_t      main_slot_addr, gfx_slot_addr;
cps_pkg::rom_data_t      slot_data;

cps_rom_map #(.MAP_SHIFT(MAP_SHIFT)) u_map (
    .clk         ( clk          ),
    .rst         ( rst          ),
    .downloading ( downloading  ),
    .ioctl_wr    ( ioctl_wr     ),
    .ioctl_addr  ( ioctl_addr   ),
    .ioctl_dout  ( ioctl_dout   ),
    .hdr_byte    ( hdr_byte     ),
    .prog_ba     ( map_ba       ),
    .prog_addr   ( map_addr     ),
    .odd_byte    ( odd_byte     )
);

cps_dwnld u_dwnld (
    .clk         ( clk          ),
    .rst         ( rst          ),
    .downloading ( downloading  ),
    .ioctl_wr    ( ioctl_wr     ),
    .ioctl_dout  ( ioctl_dout   ),
    .hdr_byte    ( hdr_byte     ),
    .odd_byte    ( odd_byte     ),
    .map_ba      ( map_ba       ),
    .map_addr    ( map_addr     ),
    .prog_addr   ( prog_addr    ),
    .prog_data   ( prog_data    ),
    .prog_mask   ( prog_mask    ),
    .prog_ba     ( prog_ba      ),
    .prog_we     ( prog_we      ),
    .prog_rdy    ( prog_rdy     ),
    .dwnld_busy  ( dwnld_busy   )
);

// Main ROM lives in bank 0
cps_rom_slot u_main_slot (
    .clk         ( clk            ),
    .rst         ( rst            ),
    .flush       ( downloading    ),
    .cs          ( main_rom_cs    ),
    .addr        ( main_rom_addr  ),
    .data        ( main_rom_data  ),
    .ok          ( main_rom_ok    ),
    .slot_req    ( main_req       ),
    .slot_ack    ( main_ack       ),
    .slot_addr   ( main_slot_addr ),
    .slot_data   ( slot_data      )
);

// Graphics ROM lives in bank 1
cps_rom_slot u_gfx_slot (
    .clk         ( clk            ),
    .rst         ( rst            ),
    .flush       ( downloading    ),
    .cs          ( gfx_rom_cs     ),
    .addr        ( gfx_rom_addr   ),
    .data        ( gfx_rom_data   ),
    .ok          ( gfx_rom_ok     ),
    .slot_req    ( gfx_req        ),
    .slot_ack    ( gfx_ack        ),
    .slot_addr   ( gfx_slot_addr  ),
    .slot_data   ( slot_data      )
);

cps_bank_arb u_arb (
    .clk         ( clk            ),
    .rst         ( rst            ),
    .downloading ( downloading    ),
    .req0        ( main_req       ),
    .req1        ( gfx_req        ),
    .ack0        ( main_ack       ),
    .ack1        ( gfx_ack        ),
    .addr0       ( main_slot_addr ),
    .addr1       ( gfx_slot_addr  ),
    .slot_data   ( slot_data      ),
    .ba_rd       ( ba_rd          ),
    .ba0_addr    ( ba0_addr       ),
    .ba1_addr    ( ba1_addr       ),
    .ba_rdy      ( ba_rdy         ),
    .data_read   ( data_read      )
);

endmodule

// File: tb_sdram_model.sv
`timescale 1ns/10ps

module tb_sdram_model (
    input                       clk,
    input                       rst,
    input  cps_pkg::rom_addr_t  prog_addr,
    input  cps_pkg::rom_data_t  prog_data,
    input        [1:0]          prog_mask,
    input        [1:0]          prog_ba,
    input                       prog_we,
    output logic                prog_rdy,
    input        [1:0]          ba_rd,
    input  cps_pkg::rom_addr_t  ba0_addr,
    input  cps_pkg::rom_addr_t  ba1_addr,
    output logic [1:0]          ba_rdy,
    output cps_pkg::rom_data_t  data_read
);

// Only the low 4096 words of each bank are modelled
cps_pkg::rom_data_t bank0 [0:4095];
cps_pkg::rom_data_t bank1 [0:4095];
logic [1:0]         wr_cnt;
logic [1:0]         rd_cnt;

// Prog write, answered 2 cycles after prog_we
always @(posedge clk) begin
    if (rst) begin
        prog_rdy <= 1'b0;
        wr_cnt   <= 2'd0;
    end else if (prog_we && !prog_rdy) begin
        if (wr_cnt == 2'd1) begin
            if (prog_ba[0] && !prog_mask[0]) bank1[prog_addr[11:0]][7:0] <= prog_data[7:0];
            if (prog_ba[0] && !prog_mask[1]) bank1[prog_addr[11:0]][15:8] <= prog_data[15:8];
            if (!prog_ba[0] && !prog_mask[0]) bank0[prog_addr[11:0]][7:0] <= prog_data[7:0];
            if (!prog_ba[0] && !prog_mask[1]) bank0[prog_addr[11:0]][15:8] <= prog_data[15:8];
            prog_rdy <= 1'b1;
            wr_cnt   <= 2'd0;
        end else begin
            wr_cnt <= wr_cnt + 2'd1;
        end
    end else if (!prog_we) begin
        prog_rdy <= 1'b0;
    end
end

// Bank read, data valid 3 cycles after ba_rd
always @(posedge clk) begin
    if (rst) begin
        ba_rdy    <= 2'b00;
        rd_cnt    <= 2'd0;
        data_read <= 16'd0;
    end else if (ba_rd != 2'b00 && ba_rdy == 2'b00) begin
        if (rd_cnt == 2'd2) begin
            data_read <= ba_rd[1] ? bank1[ba1_addr[11:0]] : bank0[ba0_addr[11:0]];
            ba_rdy    <= ba_rd;
            rd_cnt    <= 2'd0;
        end else begin
            rd_cnt <= rd_cnt + 2'd1;
        end
    end else if (ba_rd == 2'b00) begin
        ba_rdy <= 2'b00;
    end
end

endmodule

// File: tb_cps_game.sv
`timescale 1ns/10ps

module tb_cps_game;

parameter int MAP_SHIFT = 10;

localparam int N_PAYLOAD = 2048;
localparam int N_MAIN    = 64;
localparam int N_BOTH    = 32;
localparam int N_HIT     = 8;
localparam int N_BYTES   = 2 * (cps_pkg::HEADER_LEN + N_PAYLOAD);
localparam int N_READS   = N_MAIN + 2 * N_BOTH + 4 * N_HIT + 4;
localparam int WD_CYCLES = N_BYTES * 16 + N_READS * 40 + 1000;

logic                 clk;
logic                 rst;
logic                 downloading;
logic                 ioctl_wr;
cps_pkg::ioctl_addr_t ioctl_addr;
cps_pkg::byte_t       ioctl_dout;
logic                 main_rom_cs;
logic                 gfx_rom_cs;
cps_pkg::rom_addr_t   main_rom_addr;
cps_pkg::rom_addr_t   gfx_rom_addr;
wire                  dwnld_busy, prog_we, prog_rdy, main_rom_ok, gfx_rom_ok;
wire [1:0]            prog_mask, prog_ba, ba_rd, ba_rdy;
cps_pkg::rom_addr_t   prog_addr, ba0_addr, ba1_addr;
cps_pkg::rom_data_t   prog_data, main_rom_data, gfx_rom_data, data_read;

// Byte image of the last stream sent, header included
cps_pkg::byte_t       img [0:4095];
integer               seed;
integer               rnd;
int                   errors, ok_errors, ok_checks, reads_done, lat0, lat1, i;
cps_pkg::rom_addr_t   a0, a1;
cps_pkg::rom_data_t   main_exp, gfx_exp;
string                test_name;

cps_game #(.MAP_SHIFT(MAP_SHIFT)) dut_i (
    .clk(clk), .rst(rst), .downloading(downloading), .dwnld_busy(dwnld_busy),
    .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr),
    .prog_addr(prog_addr), .prog_data(prog_data), .prog_mask(prog_mask),
    .prog_ba(prog_ba), .prog_we(prog_we), .prog_rdy(prog_rdy),
    .main_rom_cs(main_rom_cs), .main_rom_addr(main_rom_addr),
    .main_rom_data(main_rom_data), .main_rom_ok(main_rom_ok),
    .gfx_rom_cs(gfx_rom_cs), .gfx_rom_addr(gfx_rom_addr),
    .gfx_rom_data(gfx_rom_data), .gfx_rom_ok(gfx_rom_ok),
    .ba_rd(ba_rd), .ba0_addr(ba0_addr), .ba1_addr(ba1_addr),
    .ba_rdy(ba_rdy), .data_read(data_read)
);

tb_sdram_model sdram_i (
    .clk(clk), .rst(rst), .prog_addr(prog_addr), .prog_data(prog_data),
    .prog_mask(prog_mask), .prog_ba(prog_ba), .prog_we(prog_we), .prog_rdy(prog_rdy),
    .ba_rd(ba_rd), .ba0_addr(ba0_addr), .ba1_addr(ba1_addr),
    .ba_rdy(ba_rdy), .data_read(data_read)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

// Expected word from the stream image and the header split rule
function automatic cps_pkg::rom_data_t ref_word(input bit bank, input cps_pkg::rom_addr_t waddr);
    int         base;
    int         off;
    logic [11:0] idx;
    base = int'({img[1], img[0]}) << MAP_SHIFT;
    off  = int'(waddr) * 2;
    if (bank) begin
        off = off + base;
    end
    off = off + cps_pkg::HEADER_LEN;
    idx = off[11:0];
    return {img[idx + 12'd1], img[idx]};
endfunction

// Every word returned with ok is compared here
always @(negedge clk) begin
    if (main_rom_ok) begin
        ok_checks++;
        main_exp = ref_word(1'b0, main_rom_addr);
        if (main_rom_data !== main_exp) begin
            $display("** Error %s main: expected %h, actual %h", test_name, main_exp,
                     main_rom_data);
            ok_errors++;
        end
    end
    if (gfx_rom_ok) begin
        ok_checks++;
        gfx_exp = ref_word(1'b1, gfx_rom_addr);
        if (gfx_rom_data !== gfx_exp) begin
            $display("** Error %s gfx: expected %h, actual %h", test_name, gfx_exp,
                     gfx_rom_data);
            ok_errors++;
        end
    end
end

task automatic download(input logic [15:0] gfx_start);
    int             k;
    int             n;
    integer         r;
    cps_pkg::byte_t b;
    downloading = 1'b1;
    for (k = 0; k < cps_pkg::HEADER_LEN + N_PAYLOAD; k++) begin
        r = $random(seed);
        b = (k == 0) ? gfx_start[7:0] : (k == 1) ? gfx_start[15:8] : r[7:0];
        img[k]     = b;
        ioctl_addr = cps_pkg::ioctl_addr_t'(k);
        ioctl_dout = b;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        if (!dwnld_busy) begin
            $display("dwnld_busy was low during the download at byte %0d", k);
            errors++;
        end
        repeat (11) @(negedge clk);
    end
    n = 0;
    while ((prog_we || prog_rdy) && n < 50) begin
        @(negedge clk);
        n++;
    end
    downloading = 1'b0;
    @(negedge clk);
    if (dwnld_busy) begin
        $display("dwnld_busy stayed high after the download ended");
        errors++;
    end
endtask

task automatic check_banks();
    int base;
    int w;
    base = int'({img[1], img[0]}) << MAP_SHIFT;
    for (w = 0; w < base / 2; w++) begin
        if (sdram_i.bank0[w[11:0]] !== ref_word(1'b0, cps_pkg::rom_addr_t'(w))) begin
            $display("** Error %s bank0[%0d]: expected %h, actual %h", test_name, w,
                     ref_word(1'b0, cps_pkg::rom_addr_t'(w)), sdram_i.bank0[w[11:0]]);
            errors++;
        end
    end
    for (w = 0; w < (N_PAYLOAD - base) / 2; w++) begin
        if (sdram_i.bank1[w[11:0]] !== ref_word(1'b1, cps_pkg::rom_addr_t'(w))) begin
            $display("** Error %s bank1[%0d]: expected %h, actual %h", test_name, w,
                     ref_word(1'b1, cps_pkg::rom_addr_t'(w)), sdram_i.bank1[w[11:0]]);
            errors++;
        end
    end
endtask

// Called on a falling edge, holds cs and addr until ok
task automatic read_slot(input bit gfx, input cps_pkg::rom_addr_t a, output int lat);
    int n;
    if (gfx) begin
        gfx_rom_cs   = 1'b1;
        gfx_rom_addr = a;
    end else begin
        main_rom_cs   = 1'b1;
        main_rom_addr = a;
    end
    @(negedge clk);
    n = 1;
    while (!(gfx ? gfx_rom_ok : main_rom_ok) && n < 200) begin
        @(negedge clk);
        n++;
    end
    if (!(gfx ? gfx_rom_ok : main_rom_ok)) begin
        $display("%s read of word %0h never got ok", gfx ? "gfx" : "main", a);
        errors++;
    end
    if (gfx) begin
        gfx_rom_cs = 1'b0;
    end else begin
        main_rom_cs = 1'b0;
    end
    reads_done++;
    lat = n;
    @(negedge clk);
endtask

initial begin
    #(WD_CYCLES * 10);
    $display("Timeout: the run did not finish within %0d cycles", WD_CYCLES);
    $display("Testbench failed");
    $finish;
end

initial begin
    seed          = 6;
    errors        = 0;
    ok_errors     = 0;
    ok_checks     = 0;
    reads_done    = 0;
    test_name     = "reset_idle";
    rst           = 1'b1;
    downloading   = 1'b0;
    ioctl_wr      = 1'b0;
    ioctl_addr    = '0;
    ioctl_dout    = '0;
    main_rom_cs   = 1'b0;
    main_rom_addr = '0;
    gfx_rom_cs    = 1'b0;
    gfx_rom_addr  = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (20) begin
        @(negedge clk);
        if ({prog_we, ba_rd, dwnld_busy, main_rom_ok, gfx_rom_ok} != 6'd0) begin
            $display("** Error %s: expected 000000, actual %b", test_name,
                     {prog_we, ba_rd, dwnld_busy, main_rom_ok, gfx_rom_ok});
            errors++;
        end
    end

    test_name = "download";
    download(16'd1);
    check_banks();

    test_name = "main_read";
    for (i = 0; i < N_MAIN; i++) begin
        rnd = $random(seed);
        read_slot(1'b0, cps_pkg::rom_addr_t'(rnd[8:0]), lat0);
    end

    // Independent addresses on both slots at once
    test_name = "both_slots";
    for (i = 0; i < N_BOTH; i++) begin
        rnd = $random(seed);
        a0  = cps_pkg::rom_addr_t'(rnd[8:0]);
        a1  = cps_pkg::rom_addr_t'(rnd[24:16]);
        fork
            read_slot(1'b0, a0, lat0);
            read_slot(1'b1, a1, lat1);
        join
    end

    test_name = "cache_hit";
    for (i = 0; i < N_HIT; i++) begin
        rnd = $random(seed);
        read_slot(1'b0, cps_pkg::rom_addr_t'(rnd[8:0]), lat0);
        read_slot(1'b0, cps_pkg::rom_addr_t'(rnd[8:0]), lat0);
        read_slot(1'b1, cps_pkg::rom_addr_t'(rnd[24:16]), lat1);
        read_slot(1'b1, cps_pkg::rom_addr_t'(rnd[24:16]), lat1);
        if (lat0 != 1 || lat1 != 1) begin
            $display("** Error %s latency: expected 1 1, actual %0d %0d", test_name,
                     lat0, lat1);
            errors++;
        end
    end

    // Cached words must not survive a new download
    test_name = "flush";
    read_slot(1'b0, 22'd5, lat0);
    read_slot(1'b1, 22'd7, lat1);
    download(16'd1);
    check_banks();
    read_slot(1'b0, 22'd5, lat0);
    read_slot(1'b1, 22'd7, lat1);

    repeat (4) @(negedge clk);
    if (ok_checks != reads_done) begin
        $display("** Error ok_count: expected %0d, actual %0d", reads_done, ok_checks);
        errors++;
    end
    $display("Checks: %0d, errors: %0d", ok_checks, errors + ok_errors);
    if (errors + ok_errors == 0) begin
        $display("Testbench passed");
    end else begin
        $display("Testbench failed");
    end
    $finish;
end

endmodule

// File: cps_mini.f
cps_pkg.sv
cps_rom_map.sv
cps_dwnld.sv
cps_rom_slot.sv
cps_bank_arb.sv
cps_game.sv
tb_sdram_model.sv
tb_cps_game.sv

// File: run_sim.sh
#!/bin/sh
# Builds the cps_mini testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_cps_game \
    -f cps_mini.f \
    --Mdir obj_dir -o sim_cps_mini
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_cps_mini > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
